//--- include/adc_capture_params.svh
`ifndef ADC_CAPTURE_PARAMS_SVH
`define ADC_CAPTURE_PARAMS_SVH

// Capture front end sizing

// Bits per ADC sample, one lane word
`define ADC_SAMPLE_W 8

// Frames held in the user-side FIFO, power of two
`define ADC_FIFO_DEPTH 16

// log2 of ADC_FIFO_DEPTH
// Pointers carry one extra wrap bit on top of this
`define ADC_FIFO_AW 4

`endif

//--- hw/adc_capture_pkg.sv
`default_nettype none

`include "adc_capture_params.svh"

package adc_capture_pkg;

   // One ADC sample as delivered on a lane
   typedef logic [`ADC_SAMPLE_W-1:0] sample_t;

   // Four samples of one channel
   // Sample 0 sits in the top byte, sample 3 in the bottom byte
   typedef logic [4*`ADC_SAMPLE_W-1:0] quad_t;

   // Frame alignment state
   typedef enum logic {
      ALIGN_SEARCH = 1'b0,  // No sync since reset, frames are not written
      ALIGN_LOCKED = 1'b1   // Phase follows the last sync
   } align_state_t;

endpackage

`default_nettype wire

//--- hw/frame_aligner.sv
`timescale 1ns/100ps
`default_nettype none

// Frame phase tracking for the capture path
// A frame spans two adc_clk cycles, first half then second half
// Sync forces a first half, otherwise the phase just alternates
module frame_aligner import adc_capture_pkg::*; (
   input  logic adc_clk,
   input  logic rst_n,
   input  logic adc_sync,        // ADC frame strobe, level per cycle
   input  logic adc_outofrange,  // ADC overrange level
   output logic first_half,      // This cycle carries samples 0 and 1
   output logic frame_wr,        // One-cycle frame strobe to the FIFO
   output logic frame_oor,       // Overrange seen in either half
   output logic frame_sync       // First half of the frame had sync
);

   align_state_t state;
   logic phase_q;     // Previous cycle was a first half
   logic is_second;   // This cycle completes a frame
   logic oor_first;   // Overrange seen in the first half
   logic sync_first;  // Sync seen in the first half

   // Sync on a would-be second half drops the partial frame and restarts here
   assign is_second  = phase_q & ~adc_sync;
   assign first_half = ~is_second;

   always_ff @(posedge adc_clk) begin
      if (!rst_n) begin
         state    <= ALIGN_SEARCH;
         phase_q  <= 1'b0;
         frame_wr <= 1'b0;
      end else begin
         if (adc_sync) begin
            state <= ALIGN_LOCKED;  // Stays locked until reset
         end
         phase_q  <= first_half;  // Next cycle is a second half
         frame_wr <= is_second & (state == ALIGN_LOCKED);
      end
   end

   // Flags of the half frame in progress
   always_ff @(posedge adc_clk) begin
      if (first_half) begin
         oor_first  <= adc_outofrange;
         sync_first <= adc_sync;
      end
   end

   // Flags launched together with frame_wr and the quads
   always_ff @(posedge adc_clk) begin
      if (is_second) begin
         frame_oor  <= oor_first | adc_outofrange;  // OR over both halves
         frame_sync <= sync_first;
      end
   end

   // Strobe only follows a sync that has already locked the phase
   a_no_wr_in_search : assert property (
      @(posedge adc_clk) disable iff (!rst_n)
      frame_wr |-> (state == ALIGN_LOCKED)
   );

   // Two cycles per frame, so strobes never touch
   a_wr_spacing : assert property (
      @(posedge adc_clk) disable iff (!rst_n)
      frame_wr |=> !frame_wr
   );

endmodule

`default_nettype wire

//--- hw/lane_deserializer.sv
`timescale 1ns/100ps
`default_nettype none

// Two-cycle deserializer for one ADC channel
// First half gives samples 0 and 1, second half samples 2 and 3
// Used once for I and once for Q
module lane_deserializer import adc_capture_pkg::*; (
   input  logic    adc_clk,
   input  logic    rst_n,
   input  logic    first_half,  // From frame_aligner
   input  sample_t lane_even,   // Even lane word of this cycle
   input  sample_t lane_odd,    // Odd lane word of this cycle
   output quad_t   quad         // Assembled frame of four samples
);

   sample_t even_first;  // Sample 0
   sample_t odd_first;   // Sample 1

   // Hold the first-half words until the frame completes
   // A new sync just overwrites them
   always_ff @(posedge adc_clk) begin
      if (first_half) begin
         even_first <= lane_even;
         odd_first  <= lane_odd;
      end
   end

   // Build the quad on the second half
   // Lands in the same cycle as frame_wr
   always_ff @(posedge adc_clk) begin
      if (!rst_n) begin
         quad <= '0;
      end else if (!first_half) begin
         quad <= {even_first,   // Sample 0
                  odd_first,    // Sample 1
                  lane_even,    // Sample 2
                  lane_odd};    // Sample 3
      end
   end

   // Quad holds its value between frames

endmodule

`default_nettype wire

//--- hw/sample_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "adc_capture_params.svh"

// Single-clock frame FIFO between the capture path and the user
// Each entry holds the I quad, the Q quad and the two frame flags
// Read strobe answered one cycle later by a valid pulse
module sample_fifo import adc_capture_pkg::*; (
   input  logic  adc_clk,
   input  logic  rst_n,
   input  logic  wr_en,      // Frame strobe
   input  quad_t wr_quad_i,
   input  quad_t wr_quad_q,
   input  logic  wr_oor,
   input  logic  wr_sync,
   input  logic  rd_en,      // Pop strobe ignored while empty
   output quad_t rd_quad_i,
   output quad_t rd_quad_q,
   output logic  rd_oor,
   output logic  rd_sync,
   output logic  rd_valid,   // High for the cycle after a pop
   output logic  empty,
   output logic  overflow    // Sticky flag for a dropped frame
);

   localparam int ENTRY_W = 2 * $bits(quad_t) + 2;  // Quads plus oor and sync

   logic [ENTRY_W-1:0]    mem [`ADC_FIFO_DEPTH];
   logic [ENTRY_W-1:0]    rd_entry;   // Registered read port
   logic [`ADC_FIFO_AW:0] wr_ptr;     // Extra MSB is the wrap bit
   logic [`ADC_FIFO_AW:0] rd_ptr;
   logic [`ADC_FIFO_AW:0] fill_cnt;   // Entries stored
   logic                  full;
   logic                  do_wr;
   logic                  do_rd;

   assign fill_cnt = wr_ptr - rd_ptr;      // Modulo pointer width
   assign empty    = (fill_cnt == '0);
   assign full     = fill_cnt[`ADC_FIFO_AW];  // Count equals depth
   assign do_wr    = wr_en & ~full;         // Full drops the frame
   assign do_rd    = rd_en & ~empty;

   // Frame storage
   always_ff @(posedge adc_clk) begin
      if (do_wr) begin
         mem[wr_ptr[`ADC_FIFO_AW-1:0]] <= {wr_quad_i, wr_quad_q, wr_oor, wr_sync};
      end
   end

   // Pointers, valid pulse and overflow
   always_ff @(posedge adc_clk) begin
      if (!rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         rd_valid <= 1'b0;
         overflow <= 1'b0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + (`ADC_FIFO_AW+1)'(1);
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + (`ADC_FIFO_AW+1)'(1);
         end
         rd_valid <= do_rd;  // One cycle per pop
         if (wr_en && full) begin
            overflow <= 1'b1;  // Held until reset
         end
      end
   end

   // Read data stays on the outputs until the next pop
   always_ff @(posedge adc_clk) begin
      if (do_rd) begin
         rd_entry <= mem[rd_ptr[`ADC_FIFO_AW-1:0]];
      end
   end

   assign {rd_quad_i, rd_quad_q, rd_oor, rd_sync} = rd_entry;

   // Dropping writes on full keeps the count within the depth
   a_fill_bound : assert property (
      @(posedge adc_clk) disable iff (!rst_n)
      fill_cnt <= (`ADC_FIFO_AW+1)'(`ADC_FIFO_DEPTH)
   );

endmodule

`default_nettype wire

//--- hw/adc_capture.sv
`timescale 1ns/100ps
`default_nettype none

// Capture front end of the dual-channel ADC
// Lane words in on adc_clk, framed quads out through the FIFO
module adc_capture import adc_capture_pkg::*; (
   input  logic    adc_clk,
   input  logic    rst_n,
   input  sample_t adc_data_even_i,  // I channel, even lane
   input  sample_t adc_data_odd_i,   // I channel, odd lane
   input  sample_t adc_data_even_q,  // Q channel, even lane
   input  sample_t adc_data_odd_q,   // Q channel, odd lane
   input  logic    adc_sync,
   input  logic    adc_outofrange,
   input  logic    user_rd_en,       // Pop strobe from the consumer
   output quad_t   user_data_i,
   output quad_t   user_data_q,
   output logic    user_outofrange,
   output logic    user_sync,
   output logic    user_data_valid,
   output logic    user_empty,
   output logic    user_overflow
);

   logic  first_half;  // Aligner phase to both deserializers
   logic  frame_wr;
   logic  frame_oor;
   logic  frame_sync;
   quad_t quad_i;
   quad_t quad_q;

   frame_aligner i_aligner (
      .adc_clk        (adc_clk),
      .rst_n          (rst_n),
      .adc_sync       (adc_sync),
      .adc_outofrange (adc_outofrange),
      .first_half     (first_half),
      .frame_wr       (frame_wr),
      .frame_oor      (frame_oor),
      .frame_sync     (frame_sync)
   );

   lane_deserializer i_deser_i (
      .adc_clk    (adc_clk),
      .rst_n      (rst_n),
      .first_half (first_half),
      .lane_even  (adc_data_even_i),
      .lane_odd   (adc_data_odd_i),
      .quad       (quad_i)
   );

   lane_deserializer i_deser_q (
      .adc_clk    (adc_clk),
      .rst_n      (rst_n),
      .first_half (first_half),
      .lane_even  (adc_data_even_q),
      .lane_odd   (adc_data_odd_q),
      .quad       (quad_q)
   );

   // Quads and flags arrive together with frame_wr
   sample_fifo i_fifo (
      .adc_clk   (adc_clk),
      .rst_n     (rst_n),
      .wr_en     (frame_wr),
      .wr_quad_i (quad_i),
      .wr_quad_q (quad_q),
      .wr_oor    (frame_oor),
      .wr_sync   (frame_sync),
      .rd_en     (user_rd_en),
      .rd_quad_i (user_data_i),
      .rd_quad_q (user_data_q),
      .rd_oor    (user_outofrange),
      .rd_sync   (user_sync),
      .rd_valid  (user_data_valid),
      .empty     (user_empty),
      .overflow  (user_overflow)
   );

endmodule

`default_nettype wire

//--- tests/adc_capture_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "adc_capture_params.svh"

module adc_capture_tb import adc_capture_pkg::*; ();

   logic    adc_clk;
   logic    rst_n;
   sample_t adc_data_even_i, adc_data_odd_i, adc_data_even_q, adc_data_odd_q;
   logic    adc_sync, adc_outofrange, user_rd_en;
   quad_t   user_data_i, user_data_q;
   logic    user_outofrange, user_sync, user_data_valid, user_empty, user_overflow;

   logic [31:0] rng_state;
   int          frames_checked = 0;
   int          sync_frames = 0;
   int          oor_frames = 0;

   // Reference model state updated on the rising edge
   sample_t m_ev_i, m_od_i, m_ev_q, m_od_q;  // First-half lane words
   logic    m_oor, m_sync;                   // First-half flags
   logic    m_locked, m_prev_first;          // Sync seen / last cycle was a first half
   logic    m_pend;                          // Frame done with its FIFO write on the next edge
   quad_t   m_frame_i, m_frame_q;
   logic    m_frame_oor, m_frame_sync;
   logic    m_ovf, m_valid;
   logic    m_run = 1'b0;                    // Out of reset
   int      m_fill;                          // Predicted FIFO occupancy
   int      m_restarts;                      // Syncs that cut a frame short
   quad_t   exp_quad_i[$], exp_quad_q[$];    // Frames the DUT stored in order
   logic    exp_oor[$], exp_sync[$];

   adc_capture i_dut (.*);

   initial begin
      adc_clk = 1'b0;
      forever #4 adc_clk = ~adc_clk;  // 8 ns period
   end

   function automatic logic [31:0] next_rand();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   function automatic logic rand_oor();
      logic [31:0] r;
      r = next_rand();
      return r[2:0] == 3'b000;  // Roughly one cycle in eight
   endfunction

   function automatic void model_reset();
      m_locked = 1'b0;
      m_prev_first = 1'b0;  // First cycle after reset is a first half
      m_pend = 1'b0;
      m_ovf = 1'b0;
      m_valid = 1'b0;
      m_fill = 0;
      m_restarts = 0;
      exp_quad_i.delete();
      exp_quad_q.delete();
      exp_oor.delete();
      exp_sync.delete();
   endfunction

   // One adc_clk cycle of the capture rules
   function automatic void model_cycle(input sample_t ev_i, od_i, ev_q, od_q,
                                       input logic sync, oor, rd);
      logic second;
      logic wr;
      logic pop;
      int   fill_b;
      // FIFO sees the frame that finished one edge earlier
      fill_b = m_fill;
      wr = m_pend && (fill_b < `ADC_FIFO_DEPTH);
      pop = rd && (fill_b != 0);
      if (m_pend && !wr) m_ovf = 1'b1;  // Frame dropped on full
      if (wr) begin
         exp_quad_i.push_back(m_frame_i);
         exp_quad_q.push_back(m_frame_q);
         exp_oor.push_back(m_frame_oor);
         exp_sync.push_back(m_frame_sync);
      end
      m_fill = fill_b + int'(wr) - int'(pop);
      m_valid = pop;  // Valid pulse follows the pop
      m_pend = 1'b0;
      // Sync marks a first half and otherwise halves alternate
      second = m_prev_first && !sync;
      if (sync && m_prev_first && m_locked) m_restarts++;  // Partial frame abandoned
      if (second) begin
         if (m_locked) begin
            m_pend = 1'b1;
            m_frame_i = {m_ev_i, m_od_i, ev_i, od_i};
            m_frame_q = {m_ev_q, m_od_q, ev_q, od_q};
            m_frame_oor = m_oor | oor;
            m_frame_sync = m_sync;
         end
      end else begin
         m_ev_i = ev_i;
         m_od_i = od_i;
         m_ev_q = ev_q;
         m_od_q = od_q;
         m_oor = oor;
         m_sync = sync;
      end
      if (sync) m_locked = 1'b1;
      m_prev_first = !second;
   endfunction

   always @(posedge adc_clk) begin
      m_run = rst_n;
      if (!rst_n) model_reset();
      else model_cycle(adc_data_even_i, adc_data_odd_i, adc_data_even_q, adc_data_odd_q,
                       adc_sync, adc_outofrange, user_rd_en);
   end

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_quad(input string what, input quad_t got, input quad_t exp);
      if (got !== exp)
         fail_now($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp)
         fail_now($sformatf("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
   endtask

   // Outputs are stable mid-cycle
   always @(negedge adc_clk) begin
      logic exp_o;
      logic exp_s;
      if (m_run) begin
         check_flag("user_data_valid", user_data_valid, m_valid);
         if (user_data_valid) begin
            if (exp_quad_i.size() == 0) begin
               fail_now("A valid pulse arrived with no frame expected");
            end else begin
               exp_o = exp_oor.pop_front();
               exp_s = exp_sync.pop_front();
               check_quad("user_data_i", user_data_i, exp_quad_i.pop_front());
               check_quad("user_data_q", user_data_q, exp_quad_q.pop_front());
               check_flag("user_outofrange", user_outofrange, exp_o);
               check_flag("user_sync", user_sync, exp_s);
               frames_checked++;
               sync_frames += int'(exp_s);
               oor_frames += int'(exp_o);
            end
         end
         check_flag("user_empty", user_empty, m_fill == 0);
         check_flag("user_overflow", user_overflow, m_ovf);
      end
   end

   // Fresh random lane words every cycle
   task automatic drive_cycle(input logic sync, input logic oor, input logic rd);
      logic [31:0] r;
      @(negedge adc_clk);
      r = next_rand();
      {adc_data_even_i, adc_data_odd_i, adc_data_even_q, adc_data_odd_q} = r;
      adc_sync = sync;
      adc_outofrange = oor;
      user_rd_en = rd;
   endtask

   task automatic realign_on_second_half();
      int n;
      n = 0;
      drive_cycle(1'b0, 1'b0, 1'b1);  // Known no-sync cycle before the phase check
      while (m_prev_first) begin
         if (n == 4) fail_now("Frame phase never reached a second half");
         else drive_cycle(1'b0, 1'b0, 1'b1);
         n++;
      end
      drive_cycle(1'b1, 1'b0, 1'b1);  // Sampled as a would-be second half
   endtask

   task automatic fill_to_overflow();
      int n;
      n = 0;
      while (!user_overflow) begin
         if (n == 6 * `ADC_FIFO_DEPTH) fail_now("Overflow never set with reads stopped");
         else drive_cycle(1'b0, rand_oor(), 1'b0);
         n++;
      end
   endtask

   task automatic drain_to_empty();
      int n;
      n = 0;
      while (!user_empty) begin
         if (n == 8 * `ADC_FIFO_DEPTH) fail_now("FIFO never drained with reads running");
         else drive_cycle(1'b0, rand_oor(), 1'b1);
         n++;
      end
   endtask

   initial begin
      int start;
      rng_state = 32'hf39d70a5;
      rst_n = 1'b0;
      {adc_data_even_i, adc_data_odd_i, adc_data_even_q, adc_data_odd_q} = '0;
      adc_sync = 1'b0;
      adc_outofrange = 1'b0;
      user_rd_en = 1'b0;
      repeat (16) drive_cycle(1'b0, 1'b0, 1'b0);
      rst_n = 1'b1;
      // Unlocked with reads ignored on an empty FIFO
      for (int i = 0; i < 40; i++) drive_cycle(1'b0, rand_oor(), 1'b1);
      // Single sync then steady framing
      drive_cycle(1'b1, 1'b0, 1'b1);
      for (int i = 0; i < 40; i++) drive_cycle(1'b0, 1'b0, 1'b1);
      if (frames_checked < 15) fail_now("Too few frames after the first sync");
      // Sync on second halves with varying gaps
      for (int j = 0; j < 4; j++) begin
         realign_on_second_half();
         repeat (j + 5) drive_cycle(1'b0, rand_oor(), 1'b1);
      end
      // Periodic sync and random overrange
      for (int i = 0; i < 80; i++) drive_cycle(i % 10 == 0, rand_oor(), 1'b1);
      // Reads stopped past the depth and then resumed
      fill_to_overflow();
      repeat (10) drive_cycle(1'b0, rand_oor(), 1'b0);
      start = frames_checked;
      drain_to_empty();
      repeat (3) drive_cycle(1'b0, 1'b0, 1'b0);
      if (frames_checked - start < `ADC_FIFO_DEPTH)
         fail_now("Fewer frames than the FIFO depth came back after overflow");
      else if (m_restarts == 0 || sync_frames == 0 || oor_frames == 0)
         fail_now("Realignment, sync or overrange frames were never seen");
      else begin
         $display("No errors");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- adc_capture.f
+incdir+include
hw/adc_capture_pkg.sv
hw/frame_aligner.sv
hw/lane_deserializer.sv
hw/sample_fifo.sv
hw/adc_capture.sv
tests/adc_capture_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the capture testbench with Verilator and run it
# Exit status is nonzero on a build error or a failing run
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert --timescale 1ns/100ps \
      -f adc_capture.f --top-module adc_capture_tb -o adc_capture_sim \
   && ./obj_dir/adc_capture_sim \
   || { echo "Simulation failed"; exit 1; }
